//--- Makefile
BUILD_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert -f build.f --top-module tb_jpeg_out \
		-Mdir $(BUILD_DIR) -o tb_jpeg_out
	./$(BUILD_DIR)/tb_jpeg_out

clean:
	rm -rf $(BUILD_DIR)

//--- build.f
design/jpeg_out_pkg.sv
design/stream_if.sv
design/code_intake.sv
design/bit_packer.sv
design/byte_serializer.sv
design/byte_stuffer.sv
design/jpeg_out_top.sv
tests/code_intake_props.sv
tests/tb_jpeg_out.sv

//--- design/bit_packer.sv
`timescale 1ns/1ps
`default_nettype none

module bit_packer (
    input  wire      clock,
    input  wire      nreset,

    stream_if.sink   code_s,
    stream_if.source word_s
);

    import jpeg_out_pkg::*;

    // number of valid bits held at the top of the accumulator
    typedef logic [$clog2(2 * WORD_BITS):0] fill_t;

    logic [2*WORD_BITS-1:0] acc_q;
    fill_t                  fill_q;
    logic                   flush_q;
    logic                   out_valid_q;
    packed_word_t           out_q;

    code_bits_t             aligned;
    logic [2*WORD_BITS-1:0] merged;
    fill_t                  merged_fill;
    logic                   code_fire;
    logic                   out_fire;

    // top word of the accumulator with the unused bits set to one
    function automatic logic [WORD_BITS-1:0] pad_top(
        input logic [2*WORD_BITS-1:0] acc,
        input fill_t                  fill
    );
        return acc[2*WORD_BITS-1 -: WORD_BITS] | ({WORD_BITS{1'b1}} >> fill);
    endfunction

    ////////////////////////////////////////////////////////////
    // append the incoming code below the bits already held

    always_comb begin
        aligned     = code_s.payload.bits << (MAX_CODE_LEN - code_s.payload.len);
        merged      = acc_q | ({aligned, {WORD_BITS{1'b0}}} >> fill_q);
        merged_fill = fill_q + fill_t'(code_s.payload.len);
    end

    assign code_s.ready = !out_valid_q && !flush_q;
    assign code_fire    = code_s.valid && code_s.ready;
    assign out_fire     = out_valid_q && word_s.ready;

    ////////////////////////////////////////////////////////////
    // word output and frame end padding

    always_ff @(posedge clock) begin
        if (nreset) begin
            acc_q       <= '0;
            fill_q      <= '0;
            flush_q     <= 1'b0;
            out_valid_q <= 1'b0;
        end else begin
            if (out_fire) begin
                out_valid_q <= 1'b0;
            end
            if (code_fire) begin
                if (merged_fill >= fill_t'(WORD_BITS)) begin
                    // split off the completed top word
                    out_valid_q <= 1'b1;
                    out_q.word  <= merged[2*WORD_BITS-1 -: WORD_BITS];
                    out_q.last  <= code_s.payload.last && (merged_fill == fill_t'(WORD_BITS));
                    acc_q       <= merged << WORD_BITS;
                    fill_q      <= merged_fill - fill_t'(WORD_BITS);
                    flush_q     <= code_s.payload.last && (merged_fill != fill_t'(WORD_BITS));
                end else if (code_s.payload.last) begin
                    out_valid_q <= 1'b1;
                    out_q.word  <= pad_top(merged, merged_fill);
                    out_q.last  <= 1'b1;
                    acc_q       <= '0;
                    fill_q      <= '0;
                end else begin
                    acc_q  <= merged;
                    fill_q <= merged_fill;
                end
            end else if (flush_q && (!out_valid_q || out_fire)) begin
                // leftover bits of the frame follow the full word
                out_valid_q <= 1'b1;
                out_q.word  <= pad_top(acc_q, fill_q);
                out_q.last  <= 1'b1;
                acc_q       <= '0;
                fill_q      <= '0;
                flush_q     <= 1'b0;
            end
        end
    end

    assign word_s.valid   = out_valid_q;
    assign word_s.payload = out_q;

endmodule

`default_nettype wire

//--- design/byte_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module byte_serializer (
    input  wire      clock,
    input  wire      nreset,

    stream_if.sink   word_s,
    stream_if.source byte_s
);

    import jpeg_out_pkg::*;

    typedef logic [$clog2(BYTES_PER_WORD)-1:0] byte_idx_t;

    packed_word_t word_q;
    byte_idx_t    idx_q;
    logic         busy_q;
    logic         word_fire;
    logic         byte_fire;
    logic         last_byte;

    assign word_s.ready = !busy_q;
    assign word_fire    = word_s.valid && word_s.ready;
    assign byte_fire    = byte_s.valid && byte_s.ready;
    assign last_byte    = (idx_q == byte_idx_t'(BYTES_PER_WORD - 1));

    always_ff @(posedge clock) begin
        if (nreset) begin
            busy_q <= 1'b0;
            idx_q  <= '0;
        end else if (word_fire) begin
            busy_q <= 1'b1;
            idx_q  <= '0;
        end else if (byte_fire) begin
            idx_q <= idx_q + 1'b1;
            if (last_byte) begin
                busy_q <= 1'b0;
            end
        end
    end

    // the word shifts up so the next byte is always at the top
    always_ff @(posedge clock) begin
        if (word_fire) begin
            word_q <= word_s.payload;
        end else if (byte_fire) begin
            word_q.word <= word_q.word << BYTE_BITS;
        end
    end

    assign byte_s.valid        = busy_q;
    assign byte_s.payload.data = word_q.word[WORD_BITS-1 -: BYTE_BITS];
    assign byte_s.payload.last = word_q.last && last_byte;

endmodule

`default_nettype wire

//--- design/byte_stuffer.sv
`timescale 1ns/1ps
`default_nettype none

module byte_stuffer (
    input  wire                                clock,
    input  wire                                nreset,

    stream_if.sink                             byte_s,

    output logic                               hsync_o,
    output logic [jpeg_out_pkg::BYTE_BITS-1:0] data_o,
    output logic                               vsync_o
);

    import jpeg_out_pkg::*;

    logic [BYTE_BITS-1:0] data_q;
    logic                 hsync_q;
    logic                 vsync_q;
    logic                 stuff_q;
    logic                 stuff_last_q;
    logic                 final_q;
    logic                 in_fire;

    // final_q holds off the next frame for a cycle so vsync drops between frames
    assign byte_s.ready = !stuff_q && !final_q;
    assign in_fire      = byte_s.valid && byte_s.ready;

    ////////////////////////////////////////////////////////////
    // marker stuffing and frame window

    always_ff @(posedge clock) begin
        if (nreset) begin
            hsync_q <= 1'b0;
            vsync_q <= 1'b0;
            stuff_q <= 1'b0;
            final_q <= 1'b0;
        end else begin
            hsync_q <= 1'b0;
            final_q <= 1'b0;
            if (stuff_q) begin
                hsync_q <= 1'b1;
                vsync_q <= 1'b1;
                stuff_q <= 1'b0;
                final_q <= stuff_last_q;
            end else if (in_fire) begin
                hsync_q <= 1'b1;
                vsync_q <= 1'b1;
                stuff_q <= (byte_s.payload.data == MARKER_BYTE);
                // a marker byte passes the frame end on to its zero byte
                final_q <= byte_s.payload.last && (byte_s.payload.data != MARKER_BYTE);
            end else if (final_q) begin
                vsync_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (stuff_q) begin
            data_q <= STUFF_BYTE;
        end else if (in_fire) begin
            data_q       <= byte_s.payload.data;
            stuff_last_q <= byte_s.payload.last;
        end
    end

    assign hsync_o = hsync_q;
    assign data_o  = data_q;
    assign vsync_o = vsync_q;

endmodule

`default_nettype wire

//--- design/code_intake.sv
`timescale 1ns/1ps
`default_nettype none

module code_intake (
    input  wire                      clock,
    input  wire                      nreset,

    input  wire                      code_req_i,
    output logic                     code_ack_o,
    input  jpeg_out_pkg::code_len_t  code_len_i,
    input  jpeg_out_pkg::code_bits_t code_bits_i,
    input  wire                      code_last_i,

    stream_if.source                 code_s
);

    import jpeg_out_pkg::*;

    // the acknowledge level is the state itself
    typedef enum logic {
        ST_IDLE,
        ST_ACK
    } state_t;

    state_t state_q;
    logic   valid_q;
    code_t  hold_q;

    ////////////////////////////////////////////////////////////
    // four-phase handshake FSM

    always_ff @(posedge clock) begin
        if (nreset) begin
            state_q <= ST_IDLE;
            valid_q <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (code_req_i) begin
                        state_q <= ST_ACK;
                        valid_q <= 1'b1;
                    end
                end
                ST_ACK: begin
                    if (valid_q && code_s.ready) begin
                        valid_q <= 1'b0;
                    end
                    // release only once the producer has dropped its request
                    // and the packer holds the code
                    if (!code_req_i && (!valid_q || code_s.ready)) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // the producer keeps the data stable while the request is high
    always_ff @(posedge clock) begin
        if (state_q == ST_IDLE && code_req_i) begin
            hold_q <= '{last: code_last_i, len: code_len_i, bits: code_bits_i};
        end
    end

    assign code_ack_o     = (state_q == ST_ACK);
    assign code_s.valid   = valid_q;
    assign code_s.payload = hold_q;

endmodule

`default_nettype wire

//--- design/jpeg_out_pkg.sv
`default_nettype none

package jpeg_out_pkg;

    ////////////////////////////////////////////////////////////
    // widths of the output chain

    localparam int WORD_BITS      = 32;
    localparam int BYTE_BITS      = 8;
    localparam int BYTES_PER_WORD = WORD_BITS / BYTE_BITS;
    localparam int MAX_CODE_LEN   = 32;

    // a marker byte in the entropy coded data must be followed by a zero byte
    localparam logic [BYTE_BITS-1:0] MARKER_BYTE = 8'hff;
    localparam logic [BYTE_BITS-1:0] STUFF_BYTE  = 8'h00;

    ////////////////////////////////////////////////////////////
    // payloads of the internal streams

    typedef logic [$clog2(MAX_CODE_LEN + 1)-1:0] code_len_t;
    typedef logic [MAX_CODE_LEN-1:0]             code_bits_t;

    // one variable length code, bits right aligned
    typedef struct packed {
        logic       last;
        code_len_t  len;
        code_bits_t bits;
    } code_t;

    typedef struct packed {
        logic                 last;
        logic [WORD_BITS-1:0] word;
    } packed_word_t;

    typedef struct packed {
        logic                 last;
        logic [BYTE_BITS-1:0] data;
    } out_byte_t;

endpackage

`default_nettype wire

//--- design/jpeg_out_top.sv
`timescale 1ns/1ps
`default_nettype none

module jpeg_out_top (
    input  wire                                    clock,
    input  wire                                    nreset,

    input  wire                                    code_req_i,
    output logic                                   code_ack_o,
    input  jpeg_out_pkg::code_len_t                code_len_i,
    input  jpeg_out_pkg::code_bits_t               code_bits_i,
    input  wire                                    code_last_i,

    output logic                                   hsync_o,
    output logic [jpeg_out_pkg::BYTE_BITS-1:0]     data_o,
    output logic                                   vsync_o
);

    import jpeg_out_pkg::*;

    ////////////////////////////////////////////////////////////
    // streams between the stages

    stream_if #(.payload_t(code_t))        code_s ();
    stream_if #(.payload_t(packed_word_t)) word_s ();
    stream_if #(.payload_t(out_byte_t))    byte_s ();

    ////////////////////////////////////////////////////////////
    // output chain

    code_intake i_code_intake (
        .clock       (clock),
        .nreset      (nreset),
        .code_req_i  (code_req_i),
        .code_ack_o  (code_ack_o),
        .code_len_i  (code_len_i),
        .code_bits_i (code_bits_i),
        .code_last_i (code_last_i),
        .code_s      (code_s)
    );

    bit_packer i_bit_packer (
        .clock  (clock),
        .nreset (nreset),
        .code_s (code_s),
        .word_s (word_s)
    );

    byte_serializer i_byte_serializer (
        .clock  (clock),
        .nreset (nreset),
        .word_s (word_s),
        .byte_s (byte_s)
    );

    byte_stuffer i_byte_stuffer (
        .clock   (clock),
        .nreset  (nreset),
        .byte_s  (byte_s),
        .hsync_o (hsync_o),
        .data_o  (data_o),
        .vsync_o (vsync_o)
    );

endmodule

`default_nettype wire

//--- design/stream_if.sv
`timescale 1ns/1ps
`default_nettype none

// valid/ready stream, a transfer happens on an edge with both high
interface stream_if #(
    parameter type payload_t = logic
) ();

    logic     valid;
    logic     ready;
    payload_t payload;

    modport source (
        output valid,
        output payload,
        input  ready
    );

    modport sink (
        input  valid,
        input  payload,
        output ready
    );

endinterface

`default_nettype wire

//--- tests/code_intake_props.sv
`timescale 1ns/1ps
`default_nettype none

module code_intake_props (
    input wire clock,
    input wire nreset,
    input wire code_req_i,
    input wire code_ack_i
);

    // the acknowledge answers a request seen on the edge it rose
    property ack_rises_with_req;
        @(posedge clock) disable iff (nreset)
            $rose(code_ack_i) |-> $past(code_req_i);
    endproperty

    property ack_falls_without_req;
        @(posedge clock) disable iff (nreset)
            $fell(code_ack_i) |-> !$past(code_req_i);
    endproperty

    property ack_low_after_reset;
        @(posedge clock) nreset |=> !code_ack_i;
    endproperty

    ack_rise_a: assert property (ack_rises_with_req)
        else $error("code_ack_o rose while code_req_i was low");
    ack_fall_a: assert property (ack_falls_without_req)
        else $error("code_ack_o fell while code_req_i was high");
    ack_reset_a: assert property (ack_low_after_reset)
        else $error("code_ack_o high after reset");

endmodule

bind code_intake code_intake_props i_props (
    .clock      (clock),
    .nreset     (nreset),
    .code_req_i (code_req_i),
    .code_ack_i (code_ack_o)
);

`default_nettype wire

//--- tests/tb_jpeg_out.sv
`timescale 1ns/1ps
`default_nettype none

module tb_jpeg_out;

    import jpeg_out_pkg::*;

    // one table row is one code offered on the four-phase input
    typedef struct packed {
        code_len_t  len;
        code_bits_t bits;
        logic       last;
        logic       gap_en;
    } stim_t;

    localparam int NUM_ENTRIES     = 25;
    localparam int WATCHDOG_CYCLES = NUM_ENTRIES * 40 + 200;

    // columns are length, right aligned bits, last of frame, random gap before the request
    localparam stim_t STIM [NUM_ENTRIES] = '{
        // byte sized codes, the frame ends on a word boundary
        '{6'd8,  32'h000000a5, 1'b0, 1'b1},
        '{6'd16, 32'h00001234, 1'b0, 1'b1},
        '{6'd8,  32'h0000005a, 1'b0, 1'b1},
        '{6'd32, 32'hdeadbeef, 1'b1, 1'b1},
        // odd lengths across word boundaries, padded at the end
        '{6'd5,  32'h00000013, 1'b0, 1'b1},
        '{6'd11, 32'h000005a3, 1'b0, 1'b1},
        '{6'd13, 32'h00001abc, 1'b0, 1'b1},
        '{6'd7,  32'h00000055, 1'b0, 1'b1},
        '{6'd3,  32'h00000005, 1'b1, 1'b1},
        // marker bytes built from several codes
        '{6'd4,  32'h0000000f, 1'b0, 1'b1},
        '{6'd4,  32'h0000000f, 1'b0, 1'b1},
        '{6'd12, 32'h00000fff, 1'b0, 1'b1},
        '{6'd4,  32'h00000000, 1'b0, 1'b1},
        '{6'd9,  32'h000001ff, 1'b0, 1'b1},
        '{6'd7,  32'h0000007f, 1'b0, 1'b1},
        '{6'd32, 32'hffffffff, 1'b0, 1'b1},
        '{6'd1,  32'h00000001, 1'b1, 1'b1},
        // back-to-back requests
        '{6'd24, 32'h00123456, 1'b0, 1'b0},
        '{6'd8,  32'h000000ff, 1'b0, 1'b0},
        '{6'd17, 32'h0001b0c3, 1'b0, 1'b0},
        '{6'd15, 32'h00007001, 1'b0, 1'b0},
        '{6'd1,  32'h00000000, 1'b1, 1'b0},
        // the last code crosses a word boundary, the padded word follows the full one
        '{6'd20, 32'h000abcde, 1'b0, 1'b1},
        '{6'd20, 32'h000fedcb, 1'b1, 1'b1},
        // a single bit frame is almost all padding
        '{6'd1,  32'h00000000, 1'b1, 1'b1}
    };

    logic                 clock = 1'b0;
    logic                 nreset;
    logic                 code_req_i;
    logic                 code_ack_o;
    code_len_t            code_len_i;
    code_bits_t           code_bits_i;
    logic                 code_last_i;
    logic                 hsync_o;
    logic [BYTE_BITS-1:0] data_o;
    logic                 vsync_o;

    logic [BYTE_BITS-1:0] exp_data[$];
    bit                   exp_last[$];
    int                   exp_idx = 0;
    bit                   await_low = 1'b0;

    jpeg_out_top i_dut (
        .clock       (clock),
        .nreset      (nreset),
        .code_req_i  (code_req_i),
        .code_ack_o  (code_ack_o),
        .code_len_i  (code_len_i),
        .code_bits_i (code_bits_i),
        .code_last_i (code_last_i),
        .hsync_o     (hsync_o),
        .data_o      (data_o),
        .vsync_o     (vsync_o)
    );

    always #50 clock = ~clock;

    ////////////////////////////////////////////////////////////
    // expected byte stream from the packing and stuffing rules

    task automatic build_expected();
        bit                   bitq[$];
        logic [BYTE_BITS-1:0] b;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            for (int k = STIM[i].len - 1; k >= 0; k--) begin
                bitq.push_back(STIM[i].bits[k]);
            end
            if (STIM[i].last) begin
                // frame end fills the partial word with ones
                while (bitq.size() % WORD_BITS != 0) begin
                    bitq.push_back(1'b1);
                end
                while (bitq.size() > 0) begin
                    for (int k = 0; k < BYTE_BITS; k++) begin
                        b = {b[BYTE_BITS-2:0], bitq.pop_front()};
                    end
                    exp_data.push_back(b);
                    exp_last.push_back(bitq.size() == 0 && b != MARKER_BYTE);
                    if (b == MARKER_BYTE) begin
                        exp_data.push_back(STUFF_BYTE);
                        exp_last.push_back(bitq.size() == 0);
                    end
                end
            end
        end
    endtask

    // four-phase producer
    task automatic send_code(input stim_t s);
        int gap;
        gap = s.gap_en ? int'($urandom % 4) : 0;
        repeat (gap) @(negedge clock);
        code_len_i  = s.len;
        code_bits_i = s.bits;
        code_last_i = s.last;
        code_req_i  = 1'b1;
        @(negedge clock);
        while (!code_ack_o) @(negedge clock);
        code_req_i = 1'b0;
        @(negedge clock);
        while (code_ack_o) @(negedge clock);
    endtask

    ////////////////////////////////////////////////////////////
    // output monitor

    always @(negedge clock) begin
        if (!nreset) begin
            if (!vsync_o) begin
                await_low = 1'b0;
            end
            if (hsync_o) begin
                assert (exp_idx < exp_data.size()) else begin
                    $display("unexpected extra byte %02h at %0t ns", data_o, $time);
                    $display("TESTBENCH FAILED");
                    $fatal(1);
                end
                assert (vsync_o && !await_low) else begin
                    $display("vsync_o did not frame byte %0d at %0t ns", exp_idx, $time);
                    $display("TESTBENCH FAILED");
                    $fatal(1);
                end
                assert (data_o == exp_data[exp_idx]) else begin
                    $display("Error at %0t ns: data_o expected %02h, actual %02h",
                             $time, exp_data[exp_idx], data_o);
                    $display("TESTBENCH FAILED");
                    $fatal(1);
                end
                await_low = exp_last[exp_idx];
                exp_idx++;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("timeout, only %0d of %0d bytes came out", exp_idx, exp_data.size());
        $display("TESTBENCH FAILED");
        $fatal(1);
    end

    initial begin
        void'($urandom(32'hcd18a3f0));
        nreset      = 1'b1;
        code_req_i  = 1'b0;
        code_len_i  = '0;
        code_bits_i = '0;
        code_last_i = 1'b0;
        build_expected();
        repeat (5) @(negedge clock);
        nreset = 1'b0;

        // quiet outputs while nothing is requested
        repeat (5) begin
            @(negedge clock);
            assert (!hsync_o && !vsync_o && !code_ack_o) else begin
                $display("outputs active without a request at %0t ns", $time);
                $display("TESTBENCH FAILED");
                $fatal(1);
            end
        end

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            send_code(STIM[i]);
        end
        while (exp_idx < exp_data.size()) @(negedge clock);
        repeat (20) @(negedge clock);

        if (vsync_o) begin
            $display("run ended with vsync_o still high after the last frame");
            $display("TESTBENCH FAILED");
            $fatal(1);
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire
